//--- Bender.yml
# Receive-side BERT checker with its testbench

package:
  name: bert_chk

sources:
  # Package first, then leaf blocks, then the top level
  - files:
      - common/bert_pkg.sv
      - hw/bert_chk/bert_ptrn_gen.sv
      - hw/bert_chk/bert_rx_cmp.sv
      - hw/bert_chk/bert_err_cnt.sv
      - hw/bert_chk/bert_chk_top.sv

  # Testbench top tb_bert_chk, its tasks are included from sim
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_bert_chk.sv

//--- common/bert_pkg.sv
/*
  Shared BERT checker definitions: buffer and lane widths, lane and pattern
  encodings, configuration struct, PRBS tap constants, lane count helper
*/

package bert_pkg;

  // --------------------------------------------------------------------------
  // Widths
  // --------------------------------------------------------------------------
  localparam int unsigned buf_w      = 128; // Reference and receive buffers
  localparam int unsigned lane_w     = 8;   // Max received bits per clock
  localparam int unsigned cnt_w      = 16;  // Error counter
  localparam int unsigned lane_cnt_w = 4;   // Holds a per-clock count up to 8

  // --------------------------------------------------------------------------
  // Encodings
  // --------------------------------------------------------------------------
  // Bits taken from rx_data on each clock
  typedef enum logic [1:0] {
    nbit1 = 2'b00, // 1 bit per clock
    nbit2 = 2'b01, // 2 bits per clock
    nbit4 = 2'b10, // 4 bits per clock
    nbit8 = 2'b11  // 8 bits per clock
  } lane_sel_t;

  // Reference sequence
  typedef enum logic [1:0] {
    prbs7   = 2'b00, // x7 + x6 + 1
    prbs15  = 2'b01, // x15 + x14 + 1
    prbs31  = 2'b10, // x31 + x28 + 1
    ptrn128 = 2'b11  // Repeating 128-bit user word
  } ptrn_sel_t;

  // Static setup, held while the checker runs
  typedef struct packed {
    ptrn_sel_t ptrn_sel; // Pattern select
    lane_sel_t lane_sel; // Lane width select
  } bert_cfg_t;

  // --------------------------------------------------------------------------
  // Polynomial taps, in bits back from the bit being generated
  // --------------------------------------------------------------------------
  localparam int unsigned prbs7_len  = 7;
  localparam int unsigned prbs7_tap  = 6;
  localparam int unsigned prbs15_len = 15;
  localparam int unsigned prbs15_tap = 14;
  localparam int unsigned prbs31_len = 31;
  localparam int unsigned prbs31_tap = 28;

  // Number of active lanes for a lane select
  function automatic logic [lane_cnt_w-1:0] lane_num(input lane_sel_t sel);
    logic [lane_cnt_w-1:0] n;
    case (sel)
      nbit1:   n = 4'd1;
      nbit2:   n = 4'd2;
      nbit4:   n = 4'd4;
      default: n = 4'd8; // nbit8
    endcase
    return n;
  endfunction

endpackage

//--- hw/bert_chk/bert_chk_top.sv
/*
  BERT receive checker top: pattern generator, receive compare, error counter
*/

`timescale 1ns/1ps

module bert_chk_top (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          rx_rst_pulse,   // Sync clear of checker state
  input  logic                          rx_start_pulse, // Begin comparing
  input  logic                          seed_in_en,     // Seed reference while idle
  input  bert_pkg::bert_cfg_t           cfg,
  input  logic [bert_pkg::lane_w-1:0]   rx_data,        // Bit 0 is earliest
  output logic [bert_pkg::buf_w-1:0]    rx_data_buf,    // Last 128 received bits
  output logic                          running,
  output logic [bert_pkg::cnt_w-1:0]    err_cnt
);

  logic [bert_pkg::lane_w-1:0] ref_top; // Expected bits, top of reference buffer
  logic [bert_pkg::lane_w-1:0] bit_err; // Per-lane mismatch

  bert_ptrn_gen bert_ptrn_gen_inst (
    .clk            (clk),
    .rstn           (rstn),
    .rx_rst_pulse   (rx_rst_pulse),
    .rx_start_pulse (rx_start_pulse),
    .seed_in_en     (seed_in_en),
    .cfg            (cfg),
    .rx_data        (rx_data),
    .running        (running),
    .ref_top        (ref_top)
  );

  bert_rx_cmp bert_rx_cmp_inst (
    .clk            (clk),
    .rstn           (rstn),
    .rx_rst_pulse   (rx_rst_pulse),
    .rx_start_pulse (rx_start_pulse),
    .running        (running),
    .cfg            (cfg),
    .rx_data        (rx_data),
    .ref_top        (ref_top),
    .rx_data_buf    (rx_data_buf),
    .bit_err        (bit_err)
  );

  bert_err_cnt bert_err_cnt_inst (
    .clk          (clk),
    .rstn         (rstn),
    .rx_rst_pulse (rx_rst_pulse),
    .running      (running),
    .cfg          (cfg),
    .bit_err      (bit_err),
    .err_cnt      (err_cnt)
  );

endmodule

//--- hw/bert_chk/bert_err_cnt.sv
/*
  Per-clock error population count and saturating 16-bit error counter
*/

`timescale 1ns/1ps

module bert_err_cnt (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        rx_rst_pulse, // Clears the counter
  input  logic                        running,
  input  bert_pkg::bert_cfg_t         cfg,
  input  logic [bert_pkg::lane_w-1:0] bit_err,
  output logic [bert_pkg::cnt_w-1:0]  err_cnt       // Sticks at all ones
);

  localparam int unsigned cnt_w      = bert_pkg::cnt_w;
  localparam int unsigned lane_cnt_w = bert_pkg::lane_cnt_w;

  logic [lane_cnt_w-1:0] lane_n;  // Active lanes
  logic [lane_cnt_w-1:0] err_inc; // Errors seen this clock
  logic [cnt_w:0]        cnt_sum; // Counter plus increment, with carry out
  logic [cnt_w-1:0]      cnt_nxt; // Saturated next count

  assign lane_n = bert_pkg::lane_num(cfg.lane_sel);

  // --------------------------------------------------------------------------
  // Population count over active lanes
  // --------------------------------------------------------------------------
  always_comb
  begin
    err_inc = '0;
    for (int j = 0; j < bert_pkg::lane_w; j++)
    begin
      if (j < lane_n)
      begin
        err_inc = err_inc + {{(lane_cnt_w-1){1'b0}}, bit_err[j]};
      end
    end
  end

  assign cnt_sum = {1'b0, err_cnt} + {{(cnt_w+1-lane_cnt_w){1'b0}}, err_inc};
  assign cnt_nxt = cnt_sum[cnt_w] ? '1 : cnt_sum[cnt_w-1:0]; // Carry out saturates

  // --------------------------------------------------------------------------
  // Error counter
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      err_cnt <= '0;
    end
    else if (rx_rst_pulse)
    begin
      err_cnt <= '0;
    end
    else if (running)
    begin
      err_cnt <= cnt_nxt;
    end
  end

  // Count only moves down through a reset pulse
  a_cnt_mono : assert property (
    @(posedge clk) disable iff (!rstn)
    !rx_rst_pulse |=> err_cnt >= $past(err_cnt)
  );

endmodule

//--- hw/bert_chk/bert_ptrn_gen.sv
/*
  Reference sequence generator: 128-bit reference buffer with self-seeding,
  PRBS7/15/31 and 128-bit pattern stepping of 1 to 8 bits per clock, run flag
*/

`timescale 1ns/1ps

module bert_ptrn_gen (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        rx_rst_pulse,   // Clears flag and buffer
  input  logic                        rx_start_pulse, // Sets running, steps once
  input  logic                        seed_in_en,     // Idle seeding from rx_data
  input  bert_pkg::bert_cfg_t         cfg,
  input  logic [bert_pkg::lane_w-1:0] rx_data,
  output logic                        running,
  output logic [bert_pkg::lane_w-1:0] ref_top         // Newest expected bits
);

  localparam int unsigned buf_w  = bert_pkg::buf_w;
  localparam int unsigned lane_w = bert_pkg::lane_w;

  logic [buf_w-1:0]                  ref_buf;  // Bit buf_w-1 is the newest bit
  logic [buf_w-1:0]                  ref_nxt;  // Buffer after this clock
  logic [buf_w+lane_w-1:0]           ref_ext;  // Buffer plus up to 8 new bits above it
  logic [bert_pkg::lane_cnt_w-1:0]   lane_n;   // Bits consumed per clock
  logic                              step_en;  // Advance the sequence

  assign lane_n  = bert_pkg::lane_num(cfg.lane_sel);
  assign step_en = running | rx_start_pulse; // Start edge already steps
  assign ref_top = ref_buf[buf_w-1 -: lane_w];

  // --------------------------------------------------------------------------
  // Running flag
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      running <= 1'b0;
    end
    else if (rx_rst_pulse)
    begin
      running <= 1'b0;                        // Reset pulse wins over start
    end
    else if (rx_start_pulse)
    begin
      running <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Next-bit extension
  // ref_ext[buf_w+i] is the i-th bit after the buffer contents, so bit
  // ref_ext[buf_w+i-k] lies k positions earlier in the sequence
  // --------------------------------------------------------------------------
  always_comb
  begin
    ref_ext = {rx_data, ref_buf};             // Seed words enter on top when idle
    if (step_en)
    begin
      case (cfg.ptrn_sel)
        bert_pkg::prbs7:
        begin
          for (int i = 0; i < lane_w; i++)
          begin
            ref_ext[buf_w+i] = ref_ext[buf_w+i-bert_pkg::prbs7_len] ^
                               ref_ext[buf_w+i-bert_pkg::prbs7_tap];
          end
        end
        bert_pkg::prbs15:
        begin
          for (int i = 0; i < lane_w; i++)
          begin
            ref_ext[buf_w+i] = ref_ext[buf_w+i-bert_pkg::prbs15_len] ^
                               ref_ext[buf_w+i-bert_pkg::prbs15_tap];
          end
        end
        bert_pkg::prbs31:
        begin
          for (int i = 0; i < lane_w; i++)
          begin
            ref_ext[buf_w+i] = ref_ext[buf_w+i-bert_pkg::prbs31_len] ^
                               ref_ext[buf_w+i-bert_pkg::prbs31_tap];
          end
        end
        default:                              // ptrn128
        begin
          for (int i = 0; i < lane_w; i++)
          begin
            ref_ext[buf_w+i] = ref_ext[i];    // Bit 128 positions back, a rotate
          end
        end
      endcase
    end
  end

  // Drop the oldest lane_n bits, keep the newest buf_w
  assign ref_nxt = ref_ext[lane_n +: buf_w];

  // --------------------------------------------------------------------------
  // Reference buffer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      ref_buf <= '0;
    end
    else if (rx_rst_pulse)
    begin
      ref_buf <= '0;
    end
    else if (step_en || seed_in_en)
    begin
      ref_buf <= ref_nxt;                     // Sequence step or seed shift
    end
  end

  // Idle without seeding leaves the reference untouched
  a_ref_hold : assert property (
    @(posedge clk) disable iff (!rstn)
    !(running || rx_start_pulse || seed_in_en || rx_rst_pulse) |=> $stable(ref_buf)
  );

endmodule

//--- hw/bert_chk/bert_rx_cmp.sv
/*
  Receive capture buffer of the last 128 bits and per-lane compare
  against the reference sequence
*/

`timescale 1ns/1ps

module bert_rx_cmp (
  input  logic                        clk,
  input  logic                        rstn,
  input  logic                        rx_rst_pulse,   // Clears capture buffer
  input  logic                        rx_start_pulse, // First captured word
  input  logic                        running,
  input  bert_pkg::bert_cfg_t         cfg,
  input  logic [bert_pkg::lane_w-1:0] rx_data,        // Bit 0 is earliest
  input  logic [bert_pkg::lane_w-1:0] ref_top,        // Expected newest bits
  output logic [bert_pkg::buf_w-1:0]  rx_data_buf,    // Bit 127 is the newest bit
  output logic [bert_pkg::lane_w-1:0] bit_err         // Mismatch, lane 0 earliest
);

  localparam int unsigned buf_w  = bert_pkg::buf_w;
  localparam int unsigned lane_w = bert_pkg::lane_w;

  logic [bert_pkg::lane_cnt_w-1:0] lane_n;   // Active lanes
  logic [buf_w+lane_w-1:0]         rx_ext;   // New word stacked on the buffer
  logic [lane_w-1:0]               top_diff; // Top 8 bits of both buffers XORed
  logic                            cap_en;   // Capture this clock

  assign lane_n = bert_pkg::lane_num(cfg.lane_sel);
  assign cap_en = running | rx_start_pulse;
  assign rx_ext = {rx_data, rx_data_buf};

  // --------------------------------------------------------------------------
  // Capture buffer
  // --------------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      rx_data_buf <= '0;
    end
    else if (rx_rst_pulse)
    begin
      rx_data_buf <= '0;
    end
    else if (cap_en)
    begin
      rx_data_buf <= rx_ext[lane_n +: buf_w]; // Shift in lane_n bits at the top
    end
  end

  // --------------------------------------------------------------------------
  // Bit error detection
  // --------------------------------------------------------------------------
  assign top_diff = ref_top ^ rx_data_buf[buf_w-1 -: lane_w];

  // Top lane_n bits move down to lanes 0..lane_n-1, unused lanes read zero
  always_comb
  begin
    bit_err = '0;
    if (running)
    begin
      bit_err = top_diff >> (lane_w - lane_n);
    end
  end

  // Unused lanes never report errors
  a_lane_mask : assert property (
    @(posedge clk) disable iff (!rstn)
    (bit_err >> lane_n) == '0
  );

endmodule

//--- sim/bert_tb_tasks.svh
/*
  Directed BERT checker tests, stream drive helpers and the value check
*/

`ifndef BERT_TB_TASKS_SVH
`define BERT_TB_TASKS_SVH

  task automatic check(input string name, input logic [bert_pkg::buf_w-1:0] got,
                       input logic [bert_pkg::buf_w-1:0] exp);
    if (got !== exp)
    begin
      $display("mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  function automatic bert_pkg::lane_sel_t lane_sel_of(input int n);
    case (n)
      1:       return bert_pkg::nbit1;
      2:       return bert_pkg::nbit2;
      4:       return bert_pkg::nbit4;
      default: return bert_pkg::nbit8;
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Stream helpers, all inputs change on the falling edge
  // ------------------------------------------------------------------------
  task automatic pulse_rst(input bert_pkg::ptrn_sel_t sel, input int n);
    @(negedge clk);
    rx_rst_pulse   = 1'b1;
    rx_start_pulse = 1'b0;
    seed_in_en     = 1'b0;
    rx_data        = '0;
    cfg.ptrn_sel   = sel;                       // New setup lands with the clear
    cfg.lane_sel   = lane_sel_of(n);
    lanes          = n;
    @(negedge clk);
    rx_rst_pulse = 1'b0;
  endtask

  // Seed words, then the start word right after with no gap
  task automatic seed_and_start(input int seed_len);
    int seed_words;
    seed_words = (seed_len + lanes - 1) / lanes;
    for (int w = 0; w < seed_words; w++)
    begin
      @(negedge clk);
      seed_in_en = 1'b1;
      rx_data    = word_at(w);
    end
    @(negedge clk);
    seed_in_en     = 1'b0;
    rx_start_pulse = 1'b1;
    rx_data        = word_at(seed_words);
    start_word     = seed_words;
    cur_word       = seed_words + 1;
  endtask

  task automatic stream_words(input int count);
    repeat (count)
    begin
      @(negedge clk);
      rx_start_pulse = 1'b0;
      rx_data        = word_at(cur_word);
      cur_word++;
    end
  endtask

  // Two more words push earlier ones through compare and count
  task automatic flush_and_sample(input logic exp_run, input int exp_errs);
    stream_words(2);
    @(negedge clk);
    check("running", running, exp_run);
    check("err_cnt", err_cnt, exp_errs);
  endtask

  task automatic expect_cleared();
    check("running", running, 1'b0);
    check("err_cnt", err_cnt, 0);
    check("rx_data_buf", rx_data_buf, 0);
  endtask

  // ------------------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------------------
  task automatic verify_reset_state();
    expect_cleared();                           // Straight out of rstn
    @(negedge clk);
    rx_start_pulse = 1'b1;                      // Leave running and a captured word
    rx_data        = '1;
    pulse_rst(bert_pkg::prbs7, 1);
    expect_cleared();
  endtask

  task automatic lock_all_prbs();
    bert_pkg::ptrn_sel_t sel;
    for (int p = 0; p < 3; p++)
    begin
      case (p)
        0:       sel = bert_pkg::prbs7;
        1:       sel = bert_pkg::prbs15;
        default: sel = bert_pkg::prbs31;
      endcase
      for (int w = 0; w < 4; w++)
      begin
        pulse_rst(sel, 1 << w);
        build_seq(sel);
        seed_and_start(seq_len(sel));
        stream_words(200);
        flush_and_sample(1'b1, 0);
        check("rx_data_buf", rx_data_buf, expected_buf(start_word, cur_word));
      end
    end
  endtask

  task automatic run_user_pattern();
    pulse_rst(bert_pkg::ptrn128, 8);
    build_seq(bert_pkg::ptrn128);
    seed_and_start(128);                        // Whole user word
    stream_words(64);
    flush_and_sample(1'b1, 0);
    check("rx_data_buf", rx_data_buf, expected_buf(start_word, cur_word));
  endtask

  task automatic count_injected_errors();
    int k;
    int hits;
    int pos;
    int first_bit;
    pulse_rst(bert_pkg::prbs31, 4);
    build_seq(bert_pkg::prbs31);
    k         = 1 + int'($urandom % 16);
    first_bit = ((bert_pkg::prbs31_len + 3) / 4) * 4; // First bit of the start word
    hits      = 0;
    while (hits < k)
    begin
      pos = first_bit + int'($urandom % (101 * 4));   // Start word plus 100 words
      if (!flip_bits[pos])
      begin
        flip_bits[pos] = 1'b1;
        hits++;
      end
    end
    seed_and_start(bert_pkg::prbs31_len);
    stream_words(100);
    flush_and_sample(1'b1, k);
  endtask

  task automatic saturate_counter();
    pulse_rst(bert_pkg::prbs7, 8);
    build_seq(bert_pkg::prbs7);
    for (int b = 8; b < 8306 * 8; b++)
      flip_bits[b] = 1'b1;                      // Every bit after the seed word inverted
    seed_and_start(bert_pkg::prbs7_len);
    stream_words(8299);
    flush_and_sample(1'b1, 65535);
    flush_and_sample(1'b1, 65535);              // Held at full scale
  endtask

  task automatic rst_during_run();
    pulse_rst(bert_pkg::prbs15, 2);
    build_seq(bert_pkg::prbs15);
    for (int b = 16; b < 36; b++)
      flip_bits[b] = 1'b1;                      // Start word and nine more, 20 bits
    seed_and_start(bert_pkg::prbs15_len);
    stream_words(30);
    flush_and_sample(1'b1, 20);
    pulse_rst(bert_pkg::prbs15, 2);             // Still running here
    expect_cleared();
    build_seq(bert_pkg::prbs15);
    seed_and_start(bert_pkg::prbs15_len);
    stream_words(50);
    flush_and_sample(1'b1, 0);
    check("rx_data_buf", rx_data_buf, expected_buf(start_word, cur_word));
  endtask

`endif

//--- sim/tb_bert_chk.sv
/*
  BERT checker testbench top: clock, reset, DUT, serial reference model
  of the received stream, watchdog and the directed test sequence
*/

`timescale 1ns/1ps

module tb_bert_chk;

  localparam int clk_period = 4;      // ns
  localparam int max_bits   = 70000;  // Longest stream, saturation test

  // Cycle budget per test, summed for the watchdog
  localparam int reset_cycles  = 8 + 6;
  localparam int lock_cycles   = 12 * (2 + 31 + 1 + 200 + 6);
  localparam int user_cycles   = 2 + 16 + 1 + 64 + 6;
  localparam int err_cycles    = 2 + 8 + 1 + 100 + 6;
  localparam int sat_cycles    = 2 + 1 + 1 + 8299 + 10;
  localparam int midrun_cycles = 2 * (2 + 8 + 1 + 50 + 6);
  localparam int margin_cycles = 8300; // Slack on the order of the saturation run
  localparam int watchdog_cycles = reset_cycles + lock_cycles + user_cycles +
                                   err_cycles + sat_cycles + midrun_cycles +
                                   margin_cycles;

  logic                         clk;
  logic                         rstn;
  logic                         rx_rst_pulse;
  logic                         rx_start_pulse;
  logic                         seed_in_en;
  bert_pkg::bert_cfg_t          cfg;
  logic [bert_pkg::lane_w-1:0]  rx_data;
  logic [bert_pkg::buf_w-1:0]   rx_data_buf;
  logic                         running;
  logic [bert_pkg::cnt_w-1:0]   err_cnt;

  logic seq_bits  [0:max_bits-1]; // Sent sequence, index 0 earliest
  logic flip_bits [0:max_bits-1]; // Channel errors laid over the sequence
  int   lanes;                    // Bits per word in the current test
  int   cur_word;                 // Next word to drive
  int   start_word;               // Word sent with the start pulse
  int   rnd_init;

  bert_chk_top bert_chk_top_inst (
    .clk            (clk),
    .rstn           (rstn),
    .rx_rst_pulse   (rx_rst_pulse),
    .rx_start_pulse (rx_start_pulse),
    .seed_in_en     (seed_in_en),
    .cfg            (cfg),
    .rx_data        (rx_data),
    .rx_data_buf    (rx_data_buf),
    .running        (running),
    .err_cnt        (err_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    $display("Testbench failed");
    $fatal(1);
  end

  // --------------------------------------------------------------------------
  // Reference model
  // --------------------------------------------------------------------------
  function automatic int seq_len(input bert_pkg::ptrn_sel_t sel);
    case (sel)
      bert_pkg::prbs7:  return bert_pkg::prbs7_len;
      bert_pkg::prbs15: return bert_pkg::prbs15_len;
      bert_pkg::prbs31: return bert_pkg::prbs31_len;
      default:          return 128;               // User word period
    endcase
  endfunction

  function automatic int seq_tap(input bert_pkg::ptrn_sel_t sel);
    case (sel)
      bert_pkg::prbs7:  return bert_pkg::prbs7_tap;
      bert_pkg::prbs15: return bert_pkg::prbs15_tap;
      default:          return bert_pkg::prbs31_tap;
    endcase
  endfunction

  // Serial generation, one bit at a time, flips cleared
  task automatic build_seq(input bert_pkg::ptrn_sel_t sel);
    int          len;
    int          tap;
    logic [31:0] r;
    len = seq_len(sel);
    tap = seq_tap(sel);
    for (int t = 0; t < max_bits; t++)
    begin
      flip_bits[t] = 1'b0;
      if (sel == bert_pkg::ptrn128)
      begin
        r = $urandom;
        seq_bits[t] = (t < len) ? r[0] : seq_bits[t-len];   // Repeat every 128 bits
      end
      else if (t < len)
        seq_bits[t] = 1'b1;                                  // Non-zero start state
      else
        seq_bits[t] = seq_bits[t-len] ^ seq_bits[t-tap];
    end
  endtask

  function automatic logic rx_bit(input int idx);
    return seq_bits[idx] ^ flip_bits[idx];
  endfunction

  // Earliest bit in bit 0, unused lanes zero
  function automatic logic [bert_pkg::lane_w-1:0] word_at(input int w);
    logic [bert_pkg::lane_w-1:0] word;
    word = '0;
    for (int j = 0; j < lanes; j++)
      word[j] = rx_bit(w * lanes + j);
    return word;
  endfunction

  // Last 128 captured bits, newest in bit 127
  function automatic logic [bert_pkg::buf_w-1:0] expected_buf(input int first_word,
                                                              input int end_word);
    logic [bert_pkg::buf_w-1:0] exp;
    int                         idx;
    exp = '0;
    for (int i = 0; i < bert_pkg::buf_w; i++)
    begin
      idx = end_word * lanes - bert_pkg::buf_w + i;
      if (idx >= first_word * lanes)
        exp[i] = rx_bit(idx);                             // Older slots stay zero
    end
    return exp;
  endfunction

  `include "bert_tb_tasks.svh"

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial
  begin
    rnd_init       = $urandom(37);                        // Seed the random stream once
    rstn           = 1'b0;
    rx_rst_pulse   = 1'b0;
    rx_start_pulse = 1'b0;
    seed_in_en     = 1'b0;
    cfg            = '0;
    rx_data        = '0;
    lanes          = 1;
    cur_word       = 0;
    start_word     = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    verify_reset_state();
    lock_all_prbs();
    run_user_pattern();
    count_injected_errors();
    saturate_counter();
    rst_during_run();
    $display("Testbench passed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+sim
common/bert_pkg.sv
hw/bert_chk/bert_ptrn_gen.sv
hw/bert_chk/bert_rx_cmp.sv
hw/bert_chk/bert_err_cnt.sv
hw/bert_chk/bert_chk_top.sv
sim/tb_bert_chk.sv
